// ==== hw/busPkg.sv ====
`default_nettype none

package busPkg;

	//////////////////////////////////////////////////
	// Frame format
	//////////////////////////////////////////////////

	localparam int FRAME_BITS     = 72;
	localparam int NODE_COUNT_DEF = 16;

	// Sent MSB first, address leads
	typedef struct packed {
		logic [3:0]  rxAddr;
		logic [63:0] payload;
		logic [3:0]  checkCode;
	} nodeFrameT;

	//////////////////////////////////////////////////
	// Register map in 32-bit words
	//////////////////////////////////////////////////

	// Word offsets inside a node's group of four
	localparam int OFS_DATA_LO = 0;
	localparam int OFS_DATA_HI = 1;
	localparam int OFS_CTRL    = 2;

	// Mask and busy flag
	localparam int ADR_STATUS  = 64;

	// Host side of the Wishbone classic port
	localparam int WB_ADR_BITS = 7;
	localparam int WB_DAT_BITS = 32;

	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [WB_ADR_BITS-1:0] adr;
		logic [WB_DAT_BITS-1:0] datW;
	} wbReqT;

endpackage

`default_nettype wire

// ==== hw/frameRegFile.sv ====
`default_nettype none
`timescale 1ns/1ps

module frameRegFile #(
	parameter int NODE_COUNT = busPkg::NODE_COUNT_DEF
) (
	input  logic                  clock,
	input  logic                  rstN,
	input  busPkg::wbReqT         wbReq,
	output logic [31:0]           wbDatR,
	output logic                  wbAck,
	input  logic                  busy,
	input  logic [NODE_COUNT-1:0] clearReq,
	output logic [NODE_COUNT-1:0] reqMask,
	output busPkg::nodeFrameT     frames [NODE_COUNT]
);

	logic [3:0]            nodeIdx;
	logic [1:0]            wordOfs;
	logic                  nodeHit;
	logic                  statusHit;
	logic                  access;
	logic                  wrEn;
	logic [NODE_COUNT-1:0] armMask;
	logic [15:0]           maskWide;
	logic [31:0]           rdData;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	// Four words per node below the status word
	assign nodeIdx   = wbReq.adr[5:2];
	assign wordOfs   = wbReq.adr[1:0];
	assign nodeHit   = !wbReq.adr[6] && (int'(nodeIdx) < NODE_COUNT);
	assign statusHit = (wbReq.adr == 7'(busPkg::ADR_STATUS));

	// A new access starts only while no ack is out
	assign access = wbReq.cyc && wbReq.stb && !wbAck;
	assign wrEn   = access && wbReq.we;

	assign maskWide = 16'(reqMask);

	// Control word write arms the node
	always_comb begin
		armMask = '0;
		if (wrEn && nodeHit && wordOfs == 2'(busPkg::OFS_CTRL)) begin
			armMask[nodeIdx] = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////

	always_comb begin
		rdData = '0;
		if (statusHit) begin
			rdData[15:0] = maskWide;
			rdData[16]   = busy;
		end else if (nodeHit) begin
			case (wordOfs)
				2'(busPkg::OFS_DATA_LO): begin
					rdData = frames[nodeIdx].payload[31:0];
				end
				2'(busPkg::OFS_DATA_HI): begin
					rdData = frames[nodeIdx].payload[63:32];
				end
				2'(busPkg::OFS_CTRL): begin
					rdData[3:0] = frames[nodeIdx].rxAddr;
					rdData[7:4] = frames[nodeIdx].checkCode;
				end
				default: begin
					rdData = '0;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Frame storage, mask and ack
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wbAck   <= 1'b0;
			reqMask <= '0;
			for (int n = 0; n < NODE_COUNT; n++) begin
				frames[n] <= '0;
			end
		end else begin
			wbAck <= access;
			// Set after clear so a fresh arm is never lost
			reqMask <= (reqMask & ~clearReq) | armMask;
			if (wrEn && nodeHit) begin
				case (wordOfs)
					2'(busPkg::OFS_DATA_LO): begin
						frames[nodeIdx].payload[31:0] <= wbReq.datW;
					end
					2'(busPkg::OFS_DATA_HI): begin
						frames[nodeIdx].payload[63:32] <= wbReq.datW;
					end
					2'(busPkg::OFS_CTRL): begin
						frames[nodeIdx].rxAddr    <= wbReq.datW[3:0];
						frames[nodeIdx].checkCode <= wbReq.datW[7:4];
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Read data is captured with the ack
	always_ff @(posedge clock) begin
		if (access) begin
			wbDatR <= rdData;
		end
	end

endmodule

`default_nettype wire

// ==== hw/busArbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module busArbiter #(
	parameter int NODE_COUNT = busPkg::NODE_COUNT_DEF
) (
	input  logic                  clock,
	input  logic                  rstN,
	input  logic [NODE_COUNT-1:0] reqMask,
	input  busPkg::nodeFrameT     frames [NODE_COUNT],
	input  logic                  busy,
	input  logic                  done,
	output logic [NODE_COUNT-1:0] clearReq,
	output busPkg::nodeFrameT     loadFrame,
	output logic                  load
);

	localparam int IDX_BITS = $clog2(NODE_COUNT);

	logic [IDX_BITS-1:0] pickIdx;
	logic                pickValid;
	logic                inFlight;
	logic                grant;

	// Lowest armed index wins
	always_comb begin
		pickIdx   = '0;
		pickValid = 1'b0;
		for (int i = NODE_COUNT - 1; i >= 0; i--) begin
			if (reqMask[i]) begin
				pickIdx   = IDX_BITS'(i);
				pickValid = 1'b1;
			end
		end
	end

	// Hold off while a frame is loaded or still on the line
	assign grant = pickValid && !busy && !inFlight;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			load     <= 1'b0;
			clearReq <= '0;
			inFlight <= 1'b0;
		end else begin
			load     <= grant;
			clearReq <= grant ? (NODE_COUNT'(1) << pickIdx) : '0;
			if (grant) begin
				inFlight <= 1'b1;
			end else if (done) begin
				inFlight <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (grant) begin
			loadFrame <= frames[pickIdx];
		end
	end

endmodule

`default_nettype wire

// ==== hw/frameSerializer.sv ====
`default_nettype none
`timescale 1ns/1ps

module frameSerializer (
	input  logic              clock,
	input  logic              rstN,
	input  busPkg::nodeFrameT loadFrame,
	input  logic              load,
	output logic              busLine,
	output logic              busy,
	output logic              done
);

	// Start bit, frame, stop bit
	localparam int SHIFT_BITS = busPkg::FRAME_BITS + 2;
	localparam int CNT_BITS   = $clog2(SHIFT_BITS);

	logic [SHIFT_BITS-1:0] shiftQ;
	logic [CNT_BITS-1:0]   bitCnt;
	logic                  lastBit;

	//////////////////////////////////////////////////
	// Line output
	//////////////////////////////////////////////////

	// MSB of the shifter drives the line
	assign busLine = shiftQ[SHIFT_BITS-1];

	// Stop bit is on the line
	assign lastBit = (bitCnt == CNT_BITS'(SHIFT_BITS - 1));
	assign done    = busy && lastBit;

	//////////////////////////////////////////////////
	// Shifter and bit counter
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rstN) begin
			// All ones keeps the line idle high
			shiftQ <= '1;
			bitCnt <= '0;
			busy   <= 1'b0;
		end else if (busy) begin
			// Ones fill in behind so the line idles at 1
			shiftQ <= {shiftQ[SHIFT_BITS-2:0], 1'b1};
			if (lastBit) begin
				busy   <= 1'b0;
				bitCnt <= '0;
			end else begin
				bitCnt <= bitCnt + 1'b1;
			end
		end else if (load) begin
			shiftQ <= {1'b0, loadFrame, 1'b1};
			bitCnt <= '0;
			busy   <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fpgaBusTop.sv ====
`default_nettype none
`timescale 1ns/1ps

module fpgaBusTop #(
	parameter int NODE_COUNT = busPkg::NODE_COUNT_DEF
) (
	input  logic          clock,
	input  logic          rstN,
	input  busPkg::wbReqT wbReq,
	output logic [31:0]   wbDatR,
	output logic          wbAck,
	output logic          busLine
);

	logic [NODE_COUNT-1:0] reqMask;
	logic [NODE_COUNT-1:0] clearReq;
	busPkg::nodeFrameT     frames [NODE_COUNT];
	busPkg::nodeFrameT     loadFrame;
	logic                  load;
	logic                  busy;
	logic                  done;

	//////////////////////////////////////////////////
	// Host registers
	//////////////////////////////////////////////////

	frameRegFile #(
		.NODE_COUNT(NODE_COUNT)
	) uRegFile (
		.clock   (clock),
		.rstN    (rstN),
		.wbReq   (wbReq),
		.wbDatR  (wbDatR),
		.wbAck   (wbAck),
		.busy    (busy),
		.clearReq(clearReq),
		.reqMask (reqMask),
		.frames  (frames)
	);

	//////////////////////////////////////////////////
	// Grant and line driver
	//////////////////////////////////////////////////

	busArbiter #(
		.NODE_COUNT(NODE_COUNT)
	) uArbiter (
		.clock    (clock),
		.rstN     (rstN),
		.reqMask  (reqMask),
		.frames   (frames),
		.busy     (busy),
		.done     (done),
		.clearReq (clearReq),
		.loadFrame(loadFrame),
		.load     (load)
	);

	frameSerializer uSerializer (
		.clock    (clock),
		.rstN     (rstN),
		.loadFrame(loadFrame),
		.load     (load),
		.busLine  (busLine),
		.busy     (busy),
		.done     (done)
	);

endmodule

`default_nettype wire

// ==== tb/fpgaBus_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

module fpgaBusAssertions (
	input logic          clock,
	input logic          rstN,
	input busPkg::wbReqT wbReq,
	input logic          wbAck,
	input logic          busLine,
	input logic          busy,
	input logic          done
);

	int   failCount = 0;
	logic started   = 1'b0;

	// Skips the first edge, before reset has reached the shifter
	always @(posedge clock) begin
		started <= 1'b1;
	end

	//////////////////////////////////////////////////
	// Wishbone classic handshake
	//////////////////////////////////////////////////

	ackOnePulse: assert property (@(posedge clock) disable iff (!rstN)
		wbAck |=> !wbAck)
	else begin
		failCount = failCount + 1;
		$error("wbAck stayed high for more than one cycle");
	end

	ackAfterStb: assert property (@(posedge clock) disable iff (!rstN)
		$rose(wbAck) |-> $past(wbReq.cyc && wbReq.stb))
	else begin
		failCount = failCount + 1;
		$error("wbAck rose without a request in the cycle before");
	end

	stbGetsAck: assert property (@(posedge clock) disable iff (!rstN)
		(wbReq.cyc && wbReq.stb && !wbAck) |=> wbAck)
	else begin
		failCount = failCount + 1;
		$error("request was not acknowledged one cycle after strobe");
	end

	//////////////////////////////////////////////////
	// Bus line levels
	//////////////////////////////////////////////////

	lineIdleInReset: assert property (@(posedge clock)
		(started && !rstN) |-> busLine)
	else begin
		failCount = failCount + 1;
		$error("bus line left idle level during reset");
	end

	lineIdleAfterReset: assert property (@(posedge clock)
		$rose(rstN) |-> busLine ##1 busLine)
	else begin
		failCount = failCount + 1;
		$error("bus line not idle right after reset release");
	end

	// Stop bit and the cycle after it
	stopBitHigh: assert property (@(posedge clock) disable iff (!rstN)
		done |-> busLine)
	else begin
		failCount = failCount + 1;
		$error("stop bit was not 1");
	end

	lineHighAfterFrame: assert property (@(posedge clock) disable iff (!rstN)
		$fell(busy) |-> busLine)
	else begin
		failCount = failCount + 1;
		$error("bus line not 1 after the end of a frame");
	end

endmodule

bind fpgaBusTop fpgaBusAssertions uAssertions (
	.clock  (clock),
	.rstN   (rstN),
	.wbReq  (wbReq),
	.wbAck  (wbAck),
	.busLine(busLine),
	.busy   (busy),
	.done   (done)
);

`default_nettype wire

// ==== tb/tb_fpgaBus.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_fpgaBus;

	// Six frames of about 76 cycles, Wishbone traffic and a margin
	localparam int          TIMEOUT_CYCLES = 1000;
	localparam logic [31:0] LFSR_SEED      = 32'h849bb696;

	logic              clock;
	logic              rstN;
	busPkg::wbReqT     wbReq;
	logic [31:0]       wbDatR;
	logic              wbAck;
	logic              busLine;

	logic [31:0]       lfsrState;
	busPkg::nodeFrameT expFrames [16];
	busPkg::nodeFrameT rxFrames [$];
	int                cycleCount;
	int                checkErrors;
	int                testsRun;
	int                testsFailed;
	int                errMark;

	fpgaBusTop #(
		.NODE_COUNT(busPkg::NODE_COUNT_DEF)
	) u_dut (
		.clock  (clock),
		.rstN   (rstN),
		.wbReq  (wbReq),
		.wbDatR (wbDatR),
		.wbAck  (wbAck),
		.busLine(busLine)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic int totalErrors();
		return checkErrors + u_dut.uAssertions.failCount;
	endfunction

	// Taps 32, 22, 2, 1
	function automatic logic [63:0] randBits(input int count);
		logic [63:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			value     = {value[62:0], fb};
		end
		return value;
	endfunction

	task automatic checkValue(input string name, input logic [71:0] expected,
			input logic [71:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			checkErrors++;
		end
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (totalErrors() == errMark) begin
			$display("test %s passed", name);
		end else begin
			testsFailed++;
			$display("test %s failed", name);
		end
		errMark = totalErrors();
	endtask

	task automatic wbAccess(input logic we, input int adr, input logic [31:0] data,
			output logic [31:0] rdata);
		busPkg::wbReqT req;
		req      = '0;
		req.cyc  = 1'b1;
		req.stb  = 1'b1;
		req.we   = we;
		req.adr  = 7'(adr);
		req.datW = data;
		@(posedge clock);
		wbReq <= req;
		do begin
			@(negedge clock);
		end while (!wbAck);
		rdata = wbDatR;
		@(posedge clock);
		wbReq <= '0;
	endtask

	task automatic wbWrite(input int adr, input logic [31:0] data);
		logic [31:0] unused;
		wbAccess(1'b1, adr, data, unused);
	endtask

	task automatic wbRead(input int adr, output logic [31:0] data);
		wbAccess(1'b0, adr, '0, data);
	endtask

	task automatic writeData(input int node);
		logic [63:0] payload;
		payload = randBits(64);
		wbWrite(node * 4 + busPkg::OFS_DATA_LO, payload[31:0]);
		wbWrite(node * 4 + busPkg::OFS_DATA_HI, payload[63:32]);
		expFrames[node].payload = payload;
	endtask

	// Control write, which also arms the node
	task automatic armNode(input int node, input logic freshCtrl);
		if (freshCtrl) begin
			expFrames[node].rxAddr    = 4'(randBits(4));
			expFrames[node].checkCode = 4'(randBits(4));
		end
		wbWrite(node * 4 + busPkg::OFS_CTRL,
			{24'h0, expFrames[node].checkCode, expFrames[node].rxAddr});
	endtask

	task automatic expectFrame(input string name, input int node);
		busPkg::nodeFrameT got;
		while (rxFrames.size() == 0) begin
			@(negedge clock);
		end
		got = rxFrames.pop_front();
		checkValue(name, expFrames[node], got);
	endtask

	//////////////////////////////////////////////////
	// Bus line monitor sampling mid-bit
	//////////////////////////////////////////////////

	initial begin
		logic [71:0] bits;
		bits = '0;
		wait (rstN === 1'b1);
		forever begin
			@(negedge busLine);
			@(negedge clock);
			assert (busLine === 1'b0) else begin
				$display("start bit on the bus line was shorter than one cycle");
				checkErrors++;
			end
			for (int i = 0; i < busPkg::FRAME_BITS; i++) begin
				@(negedge clock);
				bits = {bits[70:0], busLine};
			end
			@(negedge clock);
			assert (busLine === 1'b1) else begin
				$display("stop bit missing after a frame");
				checkErrors++;
			end
			rxFrames.push_back(bits);
		end
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("run stopped after %0d cycles with tests still pending", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0] rdata;
		logic [31:0] statusArmed;
		rstN        = 1'b0;
		wbReq       = '0;
		lfsrState   = LFSR_SEED;
		checkErrors = 0;
		testsRun    = 0;
		testsFailed = 0;
		errMark     = 0;
		foreach (expFrames[n]) begin
			expFrames[n] = '0;
		end
		repeat (8) @(posedge clock);
		rstN <= 1'b1;

		@(negedge clock);
		checkValue("resetState", 72'(1'b1), 72'(busLine));
		wbRead(busPkg::ADR_STATUS, rdata);
		checkValue("resetState", 72'(0), 72'(rdata));
		endTest("resetState");

		// Data words only, so node 5 stays unarmed
		writeData(5);
		wbRead(5 * 4 + busPkg::OFS_DATA_LO, rdata);
		checkValue("readBack", 72'(expFrames[5].payload[31:0]), 72'(rdata));
		wbRead(5 * 4 + busPkg::OFS_DATA_HI, rdata);
		checkValue("readBack", 72'(expFrames[5].payload[63:32]), 72'(rdata));
		wbRead(5 * 4 + busPkg::OFS_CTRL, rdata);
		checkValue("readBack", 72'(0), 72'(rdata));
		endTest("readBack");

		writeData(1);
		armNode(1, 1'b1);
		expectFrame("singleFrame", 1);
		// A second grant would pull the line low within a few cycles
		repeat (10) begin
			@(negedge clock);
			checkValue("singleFrame", 72'(1'b1), 72'(busLine));
		end
		endTest("singleFrame");

		// Node 1 again holds the line while 8, 2 and 4 are armed
		writeData(2);
		writeData(4);
		writeData(8);
		armNode(1, 1'b0);
		armNode(8, 1'b1);
		armNode(2, 1'b1);
		armNode(4, 1'b1);
		wbRead(busPkg::ADR_STATUS, statusArmed);
		expectFrame("priority", 1);
		expectFrame("priority", 2);
		expectFrame("priority", 4);
		expectFrame("priority", 8);
		endTest("priority");

		checkValue("status", 72'((1 << 16) | (1 << 8) | (1 << 4) | (1 << 2)), 72'(statusArmed));
		wbRead(busPkg::ADR_STATUS, rdata);
		checkValue("status", 72'(0), 72'(rdata));
		endTest("status");

		// Last node and a write to its unused fourth word
		writeData(15);
		armNode(15, 1'b1);
		wbWrite(15 * 4 + 3, 32'(randBits(32)));
		wbRead(15 * 4 + 3, rdata);
		checkValue("lastNode", 72'(0), 72'(rdata));
		wbRead(15 * 4 + busPkg::OFS_DATA_LO, rdata);
		checkValue("lastNode", 72'(expFrames[15].payload[31:0]), 72'(rdata));
		wbRead(15 * 4 + busPkg::OFS_DATA_HI, rdata);
		checkValue("lastNode", 72'(expFrames[15].payload[63:32]), 72'(rdata));
		wbRead(15 * 4 + busPkg::OFS_CTRL, rdata);
		checkValue("lastNode", 72'({expFrames[15].checkCode, expFrames[15].rxAddr}),
			72'(rdata));
		wbRead(14 * 4 + busPkg::OFS_DATA_HI, rdata);
		checkValue("lastNode", 72'(0), 72'(rdata));
		expectFrame("lastNode", 15);
		repeat (4) @(negedge clock);
		endTest("lastNode");

		$display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			testsRun, testsFailed, checkErrors, u_dut.uAssertions.failCount);
		if (testsFailed == 0 && totalErrors() == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/busPkg.sv
hw/frameRegFile.sv
hw/busArbiter.sv
hw/frameSerializer.sv
hw/fpgaBusTop.sv
tb/fpgaBus_assertions.sv
tb/tb_fpgaBus.sv

// ==== Bender.yml ====
package:
  name: fpga_bus

sources:
  - hw/busPkg.sv
  - hw/frameRegFile.sv
  - hw/busArbiter.sv
  - hw/frameSerializer.sv
  - hw/fpgaBusTop.sv
  - target: test
    files:
      - tb/fpgaBus_assertions.sv
      - tb/tb_fpgaBus.sv
